// ==== icache_pkg.sv ====
package icache_pkg;

    // Address and line geometry
    localparam int ADDR_BITS   = 16;
    localparam int OFFSET_BITS = 3;
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS;
    localparam int BLOCK_BITS  = 64;

    // Step between consecutive lines on the raw address
    localparam logic [ADDR_BITS-1:0] LINE_BYTES = 16'd1 << OFFSET_BITS;

    // Line store
    localparam int STORE_LINES      = 8;
    localparam int STORE_INDEX_BITS = $clog2(STORE_LINES);

    // Victim LFSR start value, never zero
    localparam logic [STORE_INDEX_BITS-1:0] LFSR_SEED = 3'b101;

    // Outstanding memory requests
    localparam int TRACKER_DEPTH      = 4;
    localparam int TRACKER_INDEX_BITS = $clog2(TRACKER_DEPTH);
    localparam int MEM_TAG_BITS       = 4;

    typedef logic [TAG_BITS-1:0]     line_tag_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [BLOCK_BITS-1:0]   block_t;

    // Raw word for address arithmetic, fields for tag matching
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        struct packed {
            line_tag_t              tag;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } fetch_addr_t;

    typedef struct packed {
        logic        valid;
        fetch_addr_t addr;
    } addr_packet_t;

    typedef struct packed {
        logic   valid;
        block_t data;
    } cache_data_t;

endpackage

// ==== snoop_if.sv ====
interface snoop_if;
    import icache_pkg::*;

    // Lookup issued by the prefetcher
    logic      snoop_valid;
    line_tag_t snoop_tag;

    // Answers from the store and the tracker, same cycle
    logic store_hit;
    logic store_full;
    logic tracker_hit;

    modport requester (output snoop_valid, output snoop_tag,
                       input store_hit, input store_full, input tracker_hit);

    modport store (input snoop_valid, input snoop_tag,
                   output store_hit, output store_full);

    modport tracker (input snoop_valid, input snoop_tag,
                     output tracker_hit);

endinterface

// ==== icache_store.sv ====
module icache_store (
    input  logic                           clock,
    input  logic                           reset,
    input  icache_pkg::addr_packet_t [1:0] read_addrs,
    output icache_pkg::cache_data_t  [1:0] cache_outs,
    snoop_if.store                         snoop,
    input  icache_pkg::addr_packet_t       fill,
    input  icache_pkg::block_t             fill_data
);
    import icache_pkg::*;

    // Line storage
    logic [STORE_LINES-1:0] line_valid;
    line_tag_t              line_tag  [STORE_LINES];
    block_t                 line_data [STORE_LINES];

    // Lookup results
    logic [1:0][STORE_LINES-1:0] read_match;
    logic [STORE_LINES-1:0]      snoop_match;

    // Fill placement
    logic [STORE_INDEX_BITS-1:0] lfsr;
    logic [STORE_INDEX_BITS-1:0] free_index;
    logic [STORE_INDEX_BITS-1:0] fill_index;

    // One bit per valid line holding the tag
    function automatic logic [STORE_LINES-1:0] match_lines(input line_tag_t tag);
        logic [STORE_LINES-1:0] hits;
        hits = '0;
        for (int i = 0; i < STORE_LINES; i++) begin
            hits[i] = line_valid[i] && (line_tag[i] == tag);
        end
        return hits;
    endfunction

    // Fetch reads, both ports in the same cycle
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            cache_outs[p] = '0;
            read_match[p] = match_lines(read_addrs[p].addr.fields.tag);
            for (int i = 0; i < STORE_LINES; i++) begin
                if (read_addrs[p].valid && read_match[p][i]) begin
                    cache_outs[p].valid = 1'b1;
                    cache_outs[p].data  = line_data[i];
                end
            end
        end
    end

    // Snoop answer for the prefetcher
    assign snoop_match      = match_lines(snoop.snoop_tag);
    assign snoop.store_hit  = snoop.snoop_valid && (|snoop_match);
    assign snoop.store_full = &line_valid;

    // Lowest invalid line wins
    always_comb begin
        free_index = '0;
        for (int i = STORE_LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_index = STORE_INDEX_BITS'(i);
            end
        end
    end

    // Random victim only once every line is taken
    assign fill_index = snoop.store_full ? lfsr : free_index;

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            lfsr       <= LFSR_SEED;
        end else begin
            // x^3 + x^2 + 1, runs through all seven nonzero states
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
            if (fill.valid) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill.valid) begin
            line_tag[fill_index]  <= fill.addr.fields.tag;
            line_data[fill_index] <= fill_data;
        end
    end

endmodule

// ==== miss_tracker.sv ====
module miss_tracker (
    input  logic                     clock,
    input  logic                     reset,
    snoop_if.tracker                 snoop,
    input  logic                     push,
    input  icache_pkg::mem_tag_t     push_mem_tag,
    input  icache_pkg::line_tag_t    push_line_tag,
    input  icache_pkg::mem_tag_t     mem_data_tag,
    output icache_pkg::addr_packet_t fill
);
    import icache_pkg::*;

    // Request FIFO
    logic [TRACKER_DEPTH-1:0] entry_valid;
    mem_tag_t                 entry_mem_tag  [TRACKER_DEPTH];
    line_tag_t                entry_line_tag [TRACKER_DEPTH];

    logic [TRACKER_INDEX_BITS-1:0] head;
    logic [TRACKER_INDEX_BITS-1:0] tail;

    logic [TRACKER_DEPTH-1:0] snoop_match;
    logic                     pop;

    // Any outstanding request for the snooped line
    always_comb begin
        for (int i = 0; i < TRACKER_DEPTH; i++) begin
            snoop_match[i] = entry_valid[i] && (entry_line_tag[i] == snoop.snoop_tag);
        end
    end

    assign snoop.tracker_hit = snoop.snoop_valid && (|snoop_match);

    // Returns arrive in order, so only the head can match
    assign pop = (mem_data_tag != '0) && entry_valid[head]
                 && (entry_mem_tag[head] == mem_data_tag);

    // Fill request toward the store, offset stays zero
    always_comb begin
        fill                 = '0;
        fill.valid           = pop;
        fill.addr.fields.tag = entry_line_tag[head];
    end

    // Pointers wrap naturally with a power of two depth
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            // Push after pop so a full FIFO can turn over in one cycle
            if (push) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry_mem_tag[tail]  <= push_mem_tag;
            entry_line_tag[tail] <= push_line_tag;
        end
    end

endmodule

// ==== stream_prefetcher.sv ====
module stream_prefetcher (
    input  logic                           clock,
    input  logic                           reset,
    input  icache_pkg::addr_packet_t [1:0] read_addrs,
    input  logic [1:0]                     read_hits,
    snoop_if.requester                     snoop,
    output icache_pkg::addr_packet_t       mem_req_addr,
    input  logic                           mem_req_accepted,
    input  icache_pkg::mem_tag_t           current_req_tag,
    output logic                           push,
    output icache_pkg::mem_tag_t           push_mem_tag,
    output icache_pkg::line_tag_t          push_line_tag
);
    import icache_pkg::*;

    addr_packet_t oldest_miss;
    fetch_addr_t  miss_line;
    fetch_addr_t  next_line;
    fetch_addr_t  snoop_addr;

    // Stream state
    logic        demand_valid;
    line_tag_t   demand_tag;
    fetch_addr_t stream_addr;

    logic new_demand;
    logic lookahead;
    logic present;

    // Port 0 carries the older fetch
    always_comb begin
        oldest_miss = '0;
        if (read_addrs[0].valid && !read_hits[0]) begin
            oldest_miss = read_addrs[0];
        end else if (read_addrs[1].valid && !read_hits[1]) begin
            oldest_miss = read_addrs[1];
        end
    end

    // Line base of the miss
    always_comb begin
        miss_line               = oldest_miss.addr;
        miss_line.fields.offset = '0;
    end

    assign next_line.raw = stream_addr.raw + LINE_BYTES;

    // A miss on the line already requested is not a new demand
    assign new_demand = oldest_miss.valid
                        && (!demand_valid || (oldest_miss.addr.fields.tag != demand_tag));
    assign lookahead  = !new_demand && demand_valid && !snoop.store_full;

    assign snoop_addr        = new_demand ? miss_line : next_line;
    assign snoop.snoop_valid = new_demand || lookahead;
    assign snoop.snoop_tag   = snoop_addr.fields.tag;

    // Line already resident or already on its way
    assign present = snoop.store_hit || snoop.tracker_hit;

    always_comb begin
        mem_req_addr.valid = snoop.snoop_valid && !present;
        mem_req_addr.addr  = snoop_addr;
    end

    assign push          = mem_req_addr.valid && mem_req_accepted;
    assign push_mem_tag  = current_req_tag;
    assign push_line_tag = snoop_addr.fields.tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            demand_valid <= 1'b0;
            demand_tag   <= '0;
            stream_addr  <= '0;
        end else if (new_demand) begin
            // Restart the stream at the demand line
            if (push) begin
                demand_valid <= 1'b1;
                demand_tag   <= miss_line.fields.tag;
                stream_addr  <= miss_line;
            end
        end else if (lookahead && (push || present)) begin
            // Skip over lines that need no request
            stream_addr <= next_line;
        end
    end

endmodule

// ==== icache_subsystem.sv ====
module icache_subsystem (
    input  logic                           clock,
    input  logic                           reset,

    // Fetch side, port 0 holds the older address
    input  icache_pkg::addr_packet_t [1:0] read_addrs,
    output icache_pkg::cache_data_t  [1:0] cache_outs,

    // Memory side
    input  icache_pkg::mem_tag_t           current_req_tag,
    input  icache_pkg::block_t             mem_data,
    input  icache_pkg::mem_tag_t           mem_data_tag,
    output icache_pkg::addr_packet_t       mem_req_addr,
    input  logic                           mem_req_accepted
);
    import icache_pkg::*;

    snoop_if snoop_bus ();

    // Tracker to store fill path
    addr_packet_t fill;

    // Prefetcher to tracker push path
    logic      push;
    mem_tag_t  push_mem_tag;
    line_tag_t push_line_tag;

    icache_store icache_store_i (
        .clock      (clock),
        .reset      (reset),
        .read_addrs (read_addrs),
        .cache_outs (cache_outs),
        .snoop      (snoop_bus.store),
        .fill       (fill),
        .fill_data  (mem_data)
    );

    miss_tracker miss_tracker_i (
        .clock         (clock),
        .reset         (reset),
        .snoop         (snoop_bus.tracker),
        .push          (push),
        .push_mem_tag  (push_mem_tag),
        .push_line_tag (push_line_tag),
        .mem_data_tag  (mem_data_tag),
        .fill          (fill)
    );

    stream_prefetcher stream_prefetcher_i (
        .clock            (clock),
        .reset            (reset),
        .read_addrs       (read_addrs),
        .read_hits        ({cache_outs[1].valid, cache_outs[0].valid}),
        .snoop            (snoop_bus.requester),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .push             (push),
        .push_mem_tag     (push_mem_tag),
        .push_line_tag    (push_line_tag)
    );

endmodule

// ==== icache_assert.sv ====
module icache_assert (
    input logic             clock,
    input logic             reset,
    input logic [3:0]       entry_valid,
    input logic [3:0][12:0] entry_tags,
    input logic             fill_valid,
    input logic [3:0]       mem_data_tag,
    input logic             req_valid
);

    int failures = 0;

    // True when no two valid entries hold the same line
    function automatic logic lines_unique(input logic [3:0] valid,
                                          input logic [3:0][12:0] tags);
        for (int i = 0; i < 4; i++) begin
            for (int j = i + 1; j < 4; j++) begin
                if (valid[i] && valid[j] && tags[i] == tags[j]) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // An outstanding line is pushed only once
    push_not_outstanding: assert property (
        @(posedge clock) disable iff (reset) lines_unique(entry_valid, entry_tags)
    ) else begin
        $error("tracker holds the same line twice");
        failures++;
    end

    // Every in-order return becomes a fill, and nothing else does
    fill_needs_tag: assert property (
        @(posedge clock) disable iff (reset) fill_valid == (mem_data_tag != 4'd0)
    ) else begin
        $error("fill does not line up with a nonzero returned tag");
        failures++;
    end

    request_quiet_in_reset: assert property (
        @(posedge clock) reset ##1 reset |-> !req_valid
    ) else begin
        $error("memory request valid during reset");
        failures++;
    end

endmodule

bind icache_subsystem icache_assert icache_assert_i (
    .clock        (clock),
    .reset        (reset),
    .entry_valid  (miss_tracker_i.entry_valid),
    .entry_tags   ({miss_tracker_i.entry_line_tag[3], miss_tracker_i.entry_line_tag[2],
                    miss_tracker_i.entry_line_tag[1], miss_tracker_i.entry_line_tag[0]}),
    .fill_valid   (fill.valid),
    .mem_data_tag (mem_data_tag),
    .req_valid    (mem_req_addr.valid)
);

// ==== icache_checker.sv ====
module icache_checker (
    input  logic                           clock,
    input  logic                           reset,
    input  icache_pkg::addr_packet_t [1:0] read_addrs,
    input  icache_pkg::cache_data_t  [1:0] cache_outs,
    input  icache_pkg::addr_packet_t       mem_req_addr,
    input  logic                           mem_req_accepted,
    input  icache_pkg::mem_tag_t           current_req_tag,
    input  icache_pkg::mem_tag_t           mem_data_tag,
    output int                             error_count
);
    import icache_pkg::*;

    // Requests accepted by memory and not yet returned
    logic [12:0] out_line [$];
    logic [3:0]  out_mtag [$];

    // Line returned at the last edge, it must hit now
    logic        filled_valid = 1'b0;
    logic [12:0] filled_line;

    initial error_count = 0;

    // Expected block of a line
    function automatic logic [63:0] expected_block(input logic [12:0] tag);
        return {4{3'b000, tag}} ^ 64'h5a3c_96e1_0ff0_c3a5;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report(input string text);
        $display("error at %0t: %s", $time, text);
        error_count++;
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            for (int p = 0; p < 2; p++) begin
                if (cache_outs[p].valid) begin
                    if (!read_addrs[p].valid) begin
                        report($sformatf("port %0d shows a hit with no read", p));
                    end else begin
                        check_value($sformatf("cache_outs[%0d].data", p), cache_outs[p].data,
                                    expected_block(read_addrs[p].addr.fields.tag));
                    end
                end
            end

            if (filled_valid) begin
                for (int p = 0; p < 2; p++) begin
                    if (read_addrs[p].valid && !cache_outs[p].valid &&
                        read_addrs[p].addr.fields.tag == filled_line) begin
                        report($sformatf("port %0d missed line %h right after its fill",
                                         p, filled_line));
                    end
                end
            end
            filled_valid = 1'b0;

            if (mem_req_accepted && mem_req_addr.valid) begin
                check_value("mem_req_addr.offset", mem_req_addr.addr.fields.offset, 0);
                for (int i = 0; i < out_line.size(); i++) begin
                    if (out_line[i] == mem_req_addr.addr.fields.tag) begin
                        report($sformatf("line %h requested again while outstanding",
                                         mem_req_addr.addr.fields.tag));
                    end
                end
                for (int p = 0; p < 2; p++) begin
                    if (cache_outs[p].valid &&
                        read_addrs[p].addr.fields.tag == mem_req_addr.addr.fields.tag) begin
                        report($sformatf("line %h requested while it hits in the store",
                                         mem_req_addr.addr.fields.tag));
                    end
                end
                out_line.push_back(mem_req_addr.addr.fields.tag);
                out_mtag.push_back(current_req_tag);
            end

            // Returns are in order, so only the oldest one can match
            if (mem_data_tag != 4'd0 && out_mtag.size() > 0 && out_mtag[0] == mem_data_tag) begin
                filled_valid = 1'b1;
                filled_line  = out_line[0];
                void'(out_line.pop_front());
                void'(out_mtag.pop_front());
            end
        end
    end

endmodule

// ==== icache_tb.sv ====
module icache_tb;
    import icache_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_BUDGET  = 3000;
    localparam int HIT_TIMEOUT  = 300;
    localparam int TAG_COUNT    = 4;

    logic         clock = 1'b0;
    logic         reset;
    addr_packet_t [1:0] read_addrs;
    cache_data_t  [1:0] cache_outs;
    mem_tag_t     current_req_tag;
    mem_tag_t     mem_data_tag;
    block_t       mem_data;
    addr_packet_t mem_req_addr;
    logic         mem_req_accepted;

    int     tb_errors = 0;
    int     checker_errors;
    integer mem_seed  = 32'h9a07;
    integer addr_seed = 32'h9a07;

    // Memory responder state
    logic [3:0]  q_tag  [$];
    logic [12:0] q_line [$];
    int          q_due  [$];
    logic [3:0]  next_tag;
    int          wait_left;
    int          last_due;
    int          due;
    int          cycle_count;

    icache_subsystem icache_subsystem_i (.*);

    icache_checker icache_checker_i (
        .clock (clock), .reset (reset), .read_addrs (read_addrs), .cache_outs (cache_outs),
        .mem_req_addr (mem_req_addr), .mem_req_accepted (mem_req_accepted),
        .current_req_tag (current_req_tag), .mem_data_tag (mem_data_tag),
        .error_count (checker_errors)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [63:0] mem_block(input logic [12:0] tag);
        return {4{3'b000, tag}} ^ 64'h5a3c_96e1_0ff0_c3a5;
    endfunction

    // Failures from the testbench, the checker and the assertions
    function automatic int error_total();
        return tb_errors + checker_errors + icache_subsystem_i.icache_assert_i.failures;
    endfunction

    // Memory: accept after 0 to 2 cycles, return in order 2 to 6 cycles later
    always @(posedge clock) begin
        if (reset) begin
            mem_req_accepted <= 1'b0;
            current_req_tag  <= '0;
            mem_data_tag     <= '0;
            mem_data         <= '0;
            next_tag    = 4'd1;
            wait_left   = 0;
            last_due    = 0;
            cycle_count = 0;
            q_tag.delete();
            q_line.delete();
            q_due.delete();
        end else begin
            cycle_count++;
            if (mem_req_accepted && mem_req_addr.valid) begin
                due = cycle_count + 2 + ({$random(mem_seed)} % 5);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                q_tag.push_back(current_req_tag);
                q_line.push_back(mem_req_addr.addr.fields.tag);
                q_due.push_back(due);
                next_tag = (next_tag == TAG_COUNT) ? 4'd1 : next_tag + 4'd1;
            end
            if (q_tag.size() > 0 && cycle_count >= q_due[0]) begin
                mem_data_tag <= q_tag[0];
                mem_data     <= mem_block(q_line[0]);
                void'(q_tag.pop_front());
                void'(q_line.pop_front());
                void'(q_due.pop_front());
            end else begin
                mem_data_tag <= '0;
            end
            if (!mem_req_accepted && mem_req_addr.valid && q_tag.size() < TAG_COUNT) begin
                if (wait_left == 0) begin
                    mem_req_accepted <= 1'b1;
                    current_req_tag  <= next_tag;
                    wait_left = {$random(mem_seed)} % 3;
                end else begin
                    wait_left--;
                end
            end else begin
                mem_req_accepted <= 1'b0;
            end
        end
    end

    task automatic drive_reads(input logic v0, input logic [15:0] a0,
                               input logic v1, input logic [15:0] a1);
        @(posedge clock);
        read_addrs[0] <= {v0, a0};
        read_addrs[1] <= {v1, a1};
    endtask

    task automatic wait_hit(input int port, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < HIT_TIMEOUT; n++) begin
            @(posedge clock);
            if (cache_outs[port].valid) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("error at %0t: port %0d never hit", $time, port);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        int now_errors;
        now_errors = error_total();
        if (now_errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, now_errors - errors_before);
        end
    endtask

    initial begin
        #(NUM_TESTS * TEST_BUDGET * CLOCK_PERIOD);
        $display("watchdog: the run took longer than its cycle budget");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          start;
        int          seen;
        bit          ok;
        logic [12:0] line;
        logic [12:0] first [4];

        reset            = 1'b1;
        read_addrs       = '0;
        current_req_tag  = '0;
        mem_data_tag     = '0;
        mem_data         = '0;
        mem_req_accepted = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // Idle outputs after reset
        start = error_total();
        repeat (3) @(posedge clock);
        icache_checker_i.check_value("mem_req_addr.valid", mem_req_addr.valid, 0);
        icache_checker_i.check_value("cache_outs[0].valid", cache_outs[0].valid, 0);
        icache_checker_i.check_value("cache_outs[1].valid", cache_outs[1].valid, 0);
        end_test("after_reset", start);

        // Stream of next lines behind one demand
        start = error_total();
        line  = 13'h0100;
        drive_reads(1'b1, {line, 3'b010}, 1'b0, '0);
        seen = 0;
        for (int n = 0; n < HIT_TIMEOUT && seen < 4; n++) begin
            @(posedge clock);
            if (mem_req_accepted && mem_req_addr.valid) begin
                icache_checker_i.check_value("mem_req_addr.tag", mem_req_addr.addr.fields.tag,
                                             line + seen);
                seen++;
            end
        end
        if (seen < 4) begin
            $display("error at %0t: only %0d stream requests were seen", $time, seen);
            tb_errors++;
        end
        end_test("prefetch_stream", start);

        // Oldest miss first, then the younger port
        start = error_total();
        drive_reads(1'b1, {13'h0800, 3'b000}, 1'b1, {13'h1400, 3'b100});
        @(posedge clock);
        icache_checker_i.check_value("mem_req_addr.valid", mem_req_addr.valid, 1);
        icache_checker_i.check_value("mem_req_addr.tag", mem_req_addr.addr.fields.tag, 13'h0800);
        wait_hit(0, ok);
        icache_checker_i.check_value("mem_req_addr.valid", mem_req_addr.valid, 1);
        icache_checker_i.check_value("mem_req_addr.tag", mem_req_addr.addr.fields.tag, 13'h1400);
        wait_hit(1, ok);
        end_test("demand_order", start);

        // Same line on both ports
        start = error_total();
        drive_reads(1'b1, {13'h0a55, 3'b001}, 1'b1, {13'h0a55, 3'b110});
        wait_hit(0, ok);
        wait_hit(1, ok);
        end_test("fill_and_hit", start);

        // More lines than the store holds, then re-read the first ones
        start = error_total();
        for (int i = 0; i < 20; i++) begin
            line = 13'($random(addr_seed));
            if (i < 4) begin
                first[i] = line;
            end
            drive_reads(1'b1, {line, 3'b000}, 1'b0, '0);
            wait_hit(0, ok);
        end
        for (int i = 0; i < 4; i++) begin
            drive_reads(1'b1, {first[i], 3'b011}, 1'b0, '0);
            wait_hit(0, ok);
        end
        drive_reads(1'b0, '0, 1'b0, '0);
        repeat (10) @(posedge clock);
        end_test("eviction", start);

        $display("tests run: %0d, errors: %0d", NUM_TESTS, error_total());
        if (error_total() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
icache_pkg.sv
snoop_if.sv
icache_store.sv
miss_tracker.sv
stream_prefetcher.sv
icache_subsystem.sv
icache_assert.sv
icache_checker.sv
icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache_subsystem

sources:
  - icache_pkg.sv
  - snoop_if.sv
  - icache_store.sv
  - miss_tracker.sv
  - stream_prefetcher.sv
  - icache_subsystem.sv
  - target: simulation
    files:
      - icache_assert.sv
      - icache_checker.sv
      - icache_tb.sv
